// ==== Bender.yml ====
package:
  name: ooo_issue

sources:
  - hw/ooo_pkg.sv
  - hw/dispatch_router.sv
  - hw/reservation_station.sv
  - hw/issue_merge.sv
  - hw/ooo_issue_top.sv
  - target: test
    files:
      - verif/ooo_issue_assert.sv
      - verif/ooo_issue_tb.sv

// ==== hw/dispatch_router.sv ====
`timescale 1ns/1ps

module dispatch_router (
    input  ooo_pkg::renamed_instr_t instr,
    input  logic                    dispatch_valid,
    output logic                    alu_en,
    output logic                    lsu_en,
    output ooo_pkg::rs_head_t       head,
    output logic [1:0]              src_ready,
    output ooo_pkg::alu_payload_t   alu_payload,
    output ooo_pkg::lsu_payload_t   lsu_payload
);
    import ooo_pkg::*;

    // Class decode, only one station sees the write
    always_comb begin
        alu_en = 1'b0;
        lsu_en = 1'b0;
        case (instr.fu)
            FU_ALU:  alu_en = dispatch_valid;
            FU_LSU:  lsu_en = dispatch_valid;
            default: alu_en = 1'b0;
        endcase
    end

    // Entry head shared by both stations
    always_comb begin
        head.rob_tag = instr.rob_tag;
        head.prd     = instr.prd;
        head.prs1    = instr.prs1;
        head.prs2    = instr.prs2;
    end

    assign src_ready = {instr.prs2_ready, instr.prs1_ready};  // Bit 0 is rs1

    // Raw payload reinterpreted per class
    assign alu_payload = alu_payload_t'(instr.payload);
    assign lsu_payload = lsu_payload_t'(instr.payload);

endmodule

// ==== hw/issue_merge.sv ====
`timescale 1ns/1ps

module issue_merge #(
    parameter int ISSUE_CREDITS = ooo_pkg::ISSUE_CREDITS_DEF
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  alu_cand_valid,
    input  ooo_pkg::rs_head_t     alu_cand_head,
    input  ooo_pkg::alu_payload_t alu_cand_payload,
    output logic                  alu_take,
    input  logic                  lsu_cand_valid,
    input  ooo_pkg::rs_head_t     lsu_cand_head,
    input  ooo_pkg::lsu_payload_t lsu_cand_payload,
    output logic                  lsu_take,
    input  logic                  issue_credit,
    output logic                  issue_valid,
    output ooo_pkg::issue_pkt_t   issue_pkt
);
    import ooo_pkg::*;

    credit_cnt_t credit_cnt;  // Free slots downstream
    logic        alu_prio;    // ALU wins the next tie
    logic        grant_ok;
    logic        any_take;

    // ======================================================================
    // Round-robin grant
    // ======================================================================
    assign grant_ok = (credit_cnt != '0) && !flush;
    assign alu_take = grant_ok && alu_cand_valid && (alu_prio || !lsu_cand_valid);
    assign lsu_take = grant_ok && lsu_cand_valid && (!alu_prio || !alu_cand_valid);
    assign any_take = alu_take || lsu_take;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt  <= credit_cnt_t'(ISSUE_CREDITS);
            alu_prio    <= 1'b1;
            issue_valid <= 1'b0;
        end else begin
            // Flush leaves the count alone
            credit_cnt  <= credit_cnt - credit_cnt_t'(any_take)
                         + credit_cnt_t'(issue_credit);
            issue_valid <= any_take;  // Low after a flush cycle
            if (alu_take) begin
                alu_prio <= 1'b0;
            end else if (lsu_take) begin
                alu_prio <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Issue packet register
    // ======================================================================
    always_ff @(posedge clk) begin
        if (alu_take) begin
            issue_pkt <= '{fu:      FU_ALU,
                           head:    alu_cand_head,
                           payload: OP_BITS'(alu_cand_payload)};
        end else if (lsu_take) begin
            issue_pkt <= '{fu:      FU_LSU,
                           head:    lsu_cand_head,
                           payload: OP_BITS'(lsu_cand_payload)};
        end
    end

endmodule

// ==== hw/ooo_issue_top.sv ====
`timescale 1ns/1ps

module ooo_issue_top #(
    parameter int RS_ALU_DEPTH  = ooo_pkg::RS_ALU_SIZE,
    parameter int RS_LSU_DEPTH  = ooo_pkg::RS_LSU_SIZE,
    parameter int ISSUE_CREDITS = ooo_pkg::ISSUE_CREDITS_DEF
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    dispatch_valid,
    input  ooo_pkg::renamed_instr_t dispatch_instr,
    input  ooo_pkg::wb_t            wb,
    output logic                    alu_credit,
    output logic                    lsu_credit,
    input  logic                    issue_credit,
    output logic                    issue_valid,
    output ooo_pkg::issue_pkt_t     issue_pkt
);
    import ooo_pkg::*;

    // ======================================================================
    // Dispatch routing
    // ======================================================================
    logic         alu_en;
    logic         lsu_en;
    rs_head_t     disp_head;
    logic [1:0]   disp_src_ready;
    alu_payload_t disp_alu_payload;
    lsu_payload_t disp_lsu_payload;

    dispatch_router u_router (
        .instr(dispatch_instr),
        .dispatch_valid(dispatch_valid),
        .alu_en(alu_en),
        .lsu_en(lsu_en),
        .head(disp_head),
        .src_ready(disp_src_ready),
        .alu_payload(disp_alu_payload),
        .lsu_payload(disp_lsu_payload)
    );

    // ======================================================================
    // Reservation stations
    // ======================================================================
    logic         alu_cand_valid;
    rs_head_t     alu_cand_head;
    alu_payload_t alu_cand_payload;
    logic         alu_take;
    logic         lsu_cand_valid;
    rs_head_t     lsu_cand_head;
    lsu_payload_t lsu_cand_payload;
    logic         lsu_take;

    reservation_station #(
        .T_PAYLOAD(alu_payload_t),
        .DEPTH(RS_ALU_DEPTH)
    ) u_rs_alu (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .dispatch_en(alu_en),
        .head(disp_head),
        .src_ready(disp_src_ready),
        .payload(disp_alu_payload),
        .wb(wb),
        .cand_valid(alu_cand_valid),
        .cand_head(alu_cand_head),
        .cand_payload(alu_cand_payload),
        .take(alu_take),
        .credit(alu_credit)
    );

    reservation_station #(
        .T_PAYLOAD(lsu_payload_t),
        .DEPTH(RS_LSU_DEPTH)
    ) u_rs_lsu (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .dispatch_en(lsu_en),
        .head(disp_head),
        .src_ready(disp_src_ready),
        .payload(disp_lsu_payload),
        .wb(wb),
        .cand_valid(lsu_cand_valid),
        .cand_head(lsu_cand_head),
        .cand_payload(lsu_cand_payload),
        .take(lsu_take),
        .credit(lsu_credit)
    );

    // ======================================================================
    // Issue port
    // ======================================================================
    issue_merge #(
        .ISSUE_CREDITS(ISSUE_CREDITS)
    ) u_merge (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .alu_cand_valid(alu_cand_valid),
        .alu_cand_head(alu_cand_head),
        .alu_cand_payload(alu_cand_payload),
        .alu_take(alu_take),
        .lsu_cand_valid(lsu_cand_valid),
        .lsu_cand_head(lsu_cand_head),
        .lsu_cand_payload(lsu_cand_payload),
        .lsu_take(lsu_take),
        .issue_credit(issue_credit),
        .issue_valid(issue_valid),
        .issue_pkt(issue_pkt)
    );

endmodule

// ==== hw/ooo_pkg.sv ====
package ooo_pkg;

    // ======================================================================
    // Widths and default sizes
    // ======================================================================
    localparam int XLEN              = 32;  // Data and immediate width
    localparam int PHYS_REG_BITS     = 7;
    localparam int ROB_BITS          = 4;
    localparam int OP_BITS           = 35;  // Raw class payload
    localparam int RS_ALU_SIZE       = 4;
    localparam int RS_LSU_SIZE       = 4;
    localparam int ISSUE_CREDITS_DEF = 2;

    // ======================================================================
    // Types
    // ======================================================================
    typedef enum logic {
        FU_ALU = 1'b0,
        FU_LSU = 1'b1
    } fu_class_t;

    typedef struct packed {
        logic [1:0]      alu_op;
        logic            use_imm;  // Second operand from imm
        logic [XLEN-1:0] imm;
    } alu_payload_t;

    typedef struct packed {
        logic            is_store;
        logic [1:0]      size;     // Access size code
        logic [XLEN-1:0] offset;
    } lsu_payload_t;

    typedef struct packed {
        fu_class_t                fu;
        logic [ROB_BITS-1:0]      rob_tag;
        logic [PHYS_REG_BITS-1:0] prd;
        logic [PHYS_REG_BITS-1:0] prs1;
        logic                     prs1_ready;
        logic [PHYS_REG_BITS-1:0] prs2;
        logic                     prs2_ready;
        logic [OP_BITS-1:0]       payload;  // Cast by class in the router
    } renamed_instr_t;

    // Common part of every station entry
    typedef struct packed {
        logic [ROB_BITS-1:0]      rob_tag;
        logic [PHYS_REG_BITS-1:0] prd;
        logic [PHYS_REG_BITS-1:0] prs1;
        logic [PHYS_REG_BITS-1:0] prs2;
    } rs_head_t;

    typedef struct packed {
        fu_class_t          fu;
        rs_head_t           head;
        logic [OP_BITS-1:0] payload;
    } issue_pkt_t;

    typedef struct packed {
        logic                     valid;
        logic [PHYS_REG_BITS-1:0] prd;  // Register just produced
    } wb_t;

    typedef logic [2:0] credit_cnt_t;

endpackage

// ==== hw/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station #(
    parameter type T_PAYLOAD = logic,
    parameter int  DEPTH     = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              dispatch_en,
    input  ooo_pkg::rs_head_t head,
    input  logic [1:0]        src_ready,
    input  T_PAYLOAD          payload,
    input  ooo_pkg::wb_t      wb,
    output logic              cand_valid,
    output ooo_pkg::rs_head_t cand_head,
    output T_PAYLOAD          cand_payload,
    input  logic              take,
    output logic              credit
);
    import ooo_pkg::*;

    localparam int IDX_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // ======================================================================
    // Entry storage
    // ======================================================================
    logic [DEPTH-1:0]    valid_q;
    logic [1:0]          rdy_q  [DEPTH];   // Per-source ready
    logic [IDX_BITS-1:0] age_q  [DEPTH];   // Count of younger valid entries
    rs_head_t            head_q [DEPTH];
    T_PAYLOAD            pay_q  [DEPTH];

    logic [1:0]          wake   [DEPTH];
    logic [1:0]          new_wake;
    logic [IDX_BITS-1:0] free_idx;
    logic                free_found;
    logic [IDX_BITS-1:0] sel_idx;
    logic [IDX_BITS-1:0] sel_age;
    logic                alloc;
    logic                leave;

    // Tag match against the wake-up bus
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            wake[i][0] = wb.valid && (wb.prd == head_q[i].prs1);
            wake[i][1] = wb.valid && (wb.prd == head_q[i].prs2);
        end
        new_wake[0] = wb.valid && (wb.prd == head.prs1);  // Same-cycle wake-up
        new_wake[1] = wb.valid && (wb.prd == head.prs2);
    end

    // Lowest free index wins
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_BITS'(i);
            end
        end
    end

    // ======================================================================
    // Oldest-ready select
    // ======================================================================
    always_comb begin
        cand_valid = 1'b0;
        sel_idx    = '0;
        sel_age    = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (valid_q[i] && (&rdy_q[i]) && (!cand_valid || (age_q[i] > sel_age))) begin
                cand_valid = 1'b1;
                sel_idx    = IDX_BITS'(i);
                sel_age    = age_q[i];
            end
        end
    end

    assign cand_head    = head_q[sel_idx];
    assign cand_payload = pay_q[sel_idx];

    assign alloc = dispatch_en && free_found && !flush;
    assign leave = take && cand_valid && !flush;  // Flush cancels the take

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            credit  <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                rdy_q[i] <= '0;
                age_q[i] <= '0;
            end
        end else begin
            credit <= leave;  // One pulse per entry issued
            if (flush) begin
                valid_q <= '0;
            end else begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (leave && (sel_idx == IDX_BITS'(i))) begin
                        valid_q[i] <= 1'b0;
                    end else if (valid_q[i]) begin
                        rdy_q[i] <= rdy_q[i] | wake[i];
                        // Older entries lose the leaving one as a younger neighbour
                        age_q[i] <= age_q[i] + IDX_BITS'(alloc)
                                  - IDX_BITS'(leave && (age_q[i] > sel_age));
                    end
                end
                if (alloc) begin
                    valid_q[free_idx] <= 1'b1;
                    rdy_q[free_idx]   <= src_ready | new_wake;
                    age_q[free_idx]   <= '0;  // Youngest
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            head_q[free_idx] <= head;
            pay_q[free_idx]  <= payload;
        end
    end

endmodule

// ==== sources.f ====
hw/ooo_pkg.sv
hw/dispatch_router.sv
hw/reservation_station.sv
hw/issue_merge.sv
hw/ooo_issue_top.sv
verif/ooo_issue_assert.sv
verif/ooo_issue_tb.sv

// ==== verif/issue_cases.txt ====
# D fu rob prd prs1 rdy1 prs2 rdy2 payload, all hex, fu 0 is ALU and 1 is LSU
# W prd | F | X class(A or L) count tags | P waits for the expected issues
D 0 0 10 20 0 01 1 000000001
D 0 1 11 20 0 02 1 200000002
D 0 2 12 03 1 20 0 40000abcd
D 0 3 13 20 0 20 0 7ffffffff
D 1 4 14 21 0 05 1 100000010
D 1 5 15 06 1 21 0 000000020
D 1 6 16 21 0 21 0 5deadbeef
D 1 7 17 08 1 21 0 012345678
W 20
W 21
X A 4 0 1 2 3
X L 4 4 5 6 7
P
# Oldest-ready order with late wake-ups
D 0 8 30 40 0 01 1 000000007
D 0 9 31 02 1 03 1 00000000f
D 0 a 32 41 0 04 1 01000000a
D 1 b 33 42 0 05 1 200000040
D 1 c 34 06 1 07 1 000000044
D 0 d 35 08 1 09 1 111111111
D 0 e 36 0a 1 0b 1 622222222
D 0 f 37 0c 1 0d 1 333333333
X A 4 9 d e f
X L 1 c
P
W 41
X A 1 a
P
W 40
W 42
X A 1 8
X L 1 b
P
# Flush drops the waiting pair
D 0 0 38 50 0 01 1 000000001
D 1 1 39 51 0 02 1 000000002
F
D 0 2 3a 03 1 04 1 123456789
D 1 3 3b 50 0 05 1 000000003
W 50
W 51
X A 1 2
X L 1 3
P

// ==== verif/ooo_issue_assert.sv ====
`timescale 1ns/1ps

module ooo_issue_assert (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 flush,
    input logic                 alu_take,
    input logic                 lsu_take,
    input ooo_pkg::credit_cnt_t credit_cnt,
    input logic                 issue_valid
);

    // ======================================================================
    // Issue merger rules
    // ======================================================================
    no_take_without_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        (credit_cnt == '0) |-> !(alu_take || lsu_take)
    ) else $error("Take granted with zero issue credits");

    // Flushed take never reaches the issue port
    no_issue_after_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush ##1 !(alu_take || lsu_take) |=> !issue_valid
    ) else $error("Issue valid two cycles after a flush without a take");

    single_take: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(alu_take && lsu_take)
    ) else $error("Both stations granted in one cycle");

endmodule

bind issue_merge ooo_issue_assert u_merge_assert (
    .clk(clk),
    .rst_n(rst_n),
    .flush(flush),
    .alu_take(alu_take),
    .lsu_take(lsu_take),
    .credit_cnt(credit_cnt),
    .issue_valid(issue_valid)
);

// ==== verif/ooo_issue_tb.sv ====
`timescale 1ns/1ps

module ooo_issue_tb;
    import ooo_pkg::*;

    localparam int          ALU_DEPTH  = RS_ALU_SIZE;
    localparam int          LSU_DEPTH  = RS_LSU_SIZE;
    localparam int          CREDITS    = ISSUE_CREDITS_DEF;
    localparam int          NUM_TAGS   = 1 << ROB_BITS;
    localparam int          WAIT_LIMIT = 300;  // Cycles per wait loop
    localparam logic [31:0] RNG_SEED   = 32'he8622ac7;

    logic           clk;
    logic           rst_n;
    logic           flush;
    logic           dispatch_valid;
    renamed_instr_t dispatch_instr;
    wb_t            wb;
    logic           alu_credit;
    logic           lsu_credit;
    logic           issue_credit;
    logic           issue_valid;
    issue_pkt_t     issue_pkt;

    // Upstream and execution side model
    credit_cnt_t         alu_cnt;
    credit_cnt_t         lsu_cnt;
    renamed_instr_t      rec [NUM_TAGS];  // Last dispatch per rob tag
    logic [1:0]          rdy [NUM_TAGS];
    logic [NUM_TAGS-1:0] live;
    logic [ROB_BITS-1:0] exp_alu [$];
    logic [ROB_BITS-1:0] exp_lsu [$];
    issue_pkt_t          obs_alu [$];     // Issued in this phase, in order
    issue_pkt_t          obs_lsu [$];
    int                  credit_due [$];  // Cycle of each pending issue credit
    int                  cycle_cnt;
    int                  issued_cnt;
    int                  returned_cnt;

    ooo_issue_top #(
        .RS_ALU_DEPTH(ALU_DEPTH),
        .RS_LSU_DEPTH(LSU_DEPTH),
        .ISSUE_CREDITS(CREDITS)
    ) u_ooo_issue_top (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .dispatch_valid(dispatch_valid),
        .dispatch_instr(dispatch_instr),
        .wb(wb),
        .alu_credit(alu_credit),
        .lsu_credit(lsu_credit),
        .issue_credit(issue_credit),
        .issue_valid(issue_valid),
        .issue_pkt(issue_pkt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ======================================================================
    // Checks
    // ======================================================================
    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_issue(issue_pkt_t act, issue_pkt_t want);
        if (act !== want) begin
            stop_run($sformatf("ERROR @%0t: issue packet %h, expected %h", $time, act, want));
        end
    endtask

    task automatic check_credit(credit_cnt_t act, credit_cnt_t want, string what);
        if (act !== want) begin
            stop_run($sformatf("ERROR @%0t: %s %0d, expected %0d", $time, what, act, want));
        end
    endtask

    function automatic credit_cnt_t live_count(fu_class_t fu);
        credit_cnt_t n;
        n = '0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (live[i] && rec[i].fu == fu) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    // Free credits plus waiting entries always equal the depth
    task automatic check_counts();
        check_credit(alu_cnt, credit_cnt_t'(ALU_DEPTH) - live_count(FU_ALU), "ALU credits");
        check_credit(lsu_cnt, credit_cnt_t'(LSU_DEPTH) - live_count(FU_LSU), "LSU credits");
    endtask

    function automatic issue_pkt_t expected_pkt(logic [ROB_BITS-1:0] tag);
        issue_pkt_t pkt;
        pkt.fu           = rec[tag].fu;
        pkt.head.rob_tag = rec[tag].rob_tag;
        pkt.head.prd     = rec[tag].prd;
        pkt.head.prs1    = rec[tag].prs1;
        pkt.head.prs2    = rec[tag].prs2;
        pkt.payload      = rec[tag].payload;  // Raw bits pass through
        return pkt;
    endfunction

    task automatic take_issue(issue_pkt_t pkt);
        logic [ROB_BITS-1:0] tag;
        tag = pkt.head.rob_tag;
        if (!live[tag]) begin
            stop_run($sformatf("ERROR @%0t: flushed or unknown tag %0h issued", $time, tag));
        end
        if (rdy[tag] != 2'b11) begin
            stop_run($sformatf("ERROR @%0t: tag %0h issued before wake-up", $time, tag));
        end
        if (pkt.fu == FU_ALU) begin
            obs_alu.push_back(pkt);
        end else begin
            obs_lsu.push_back(pkt);
        end
        live[tag] = 1'b0;
        issued_cnt++;
        credit_due.push_back(cycle_cnt + int'($urandom % 6));
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (alu_credit) alu_cnt = alu_cnt + 1'b1;
            if (lsu_credit) lsu_cnt = lsu_cnt + 1'b1;
            if (alu_cnt > credit_cnt_t'(ALU_DEPTH) || lsu_cnt > credit_cnt_t'(LSU_DEPTH)) begin
                stop_run($sformatf("ERROR @%0t: credit pulse with no entry left", $time));
            end
            if (issue_valid) take_issue(issue_pkt);
            if (issued_cnt - returned_cnt > CREDITS) begin
                stop_run($sformatf("ERROR @%0t: %0d issues without credit", $time,
                                   issued_cnt - returned_cnt));
            end
            if (issue_credit) returned_cnt++;
        end
    end

    // Execution side hands credits back after a random delay
    initial begin : credit_return
        int idx;
        issue_credit = 1'b0;
        cycle_cnt    = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            #2;
            issue_credit = 1'b0;
            idx          = -1;
            foreach (credit_due[i]) begin
                if (idx < 0 && credit_due[i] <= cycle_cnt) idx = i;
            end
            if (idx >= 0) begin
                issue_credit = 1'b1;
                credit_due.delete(idx);
            end
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic next_cycle();
        @(posedge clk);
        #2;
        dispatch_valid = 1'b0;
        wb             = '0;
        flush          = 1'b0;
    endtask

    task automatic send_dispatch(renamed_instr_t ins);
        int waited;
        waited = 0;
        next_cycle();
        while ((ins.fu == FU_ALU) ? (alu_cnt == '0) : (lsu_cnt == '0)) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) stop_run("Timed out waiting for a dispatch credit");
        end
        check_counts();
        dispatch_valid = 1'b1;
        dispatch_instr = ins;
        if (ins.fu == FU_ALU) alu_cnt = alu_cnt - 1'b1;
        else lsu_cnt = lsu_cnt - 1'b1;
        rec[ins.rob_tag]  = ins;
        rdy[ins.rob_tag]  = {ins.prs2_ready, ins.prs1_ready};
        live[ins.rob_tag] = 1'b1;
    endtask

    task automatic send_wake(logic [PHYS_REG_BITS-1:0] prd);
        next_cycle();
        check_counts();
        wb.valid = 1'b1;
        wb.prd   = prd;
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (live[i] && rec[i].prs1 == prd) rdy[i][0] = 1'b1;
            if (live[i] && rec[i].prs2 == prd) rdy[i][1] = 1'b1;
        end
    endtask

    task automatic send_flush();
        next_cycle();
        flush   = 1'b1;
        live    = '0;
        alu_cnt = credit_cnt_t'(ALU_DEPTH);  // Upstream refills both pools
        lsu_cnt = credit_cnt_t'(LSU_DEPTH);
    endtask

    // Phase end, issues are compared in order per class
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (obs_alu.size() < exp_alu.size() || obs_lsu.size() < exp_lsu.size()) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) stop_run("Timed out waiting for the expected issues");
        end
        while (exp_alu.size() != 0) begin
            check_issue(obs_alu.pop_front(), expected_pkt(exp_alu.pop_front()));
        end
        while (exp_lsu.size() != 0) begin
            check_issue(obs_lsu.pop_front(), expected_pkt(exp_lsu.pop_front()));
        end
        if (obs_alu.size() != 0 || obs_lsu.size() != 0) begin
            stop_run($sformatf("ERROR @%0t: more issues than expected in this phase", $time));
        end
        check_counts();
    endtask

    task automatic skip_line(int fd);
        int c;
        c = $fgetc(fd);
        while (c != "\n" && c != -1) c = $fgetc(fd);
    endtask

    initial begin : stimulus
        int                 fd;
        int                 ch;
        int                 rc;
        int                 n;
        int                 val;
        int                 waited;
        int                 f_fu, f_rob, f_prd, f_p1, f_r1, f_p2, f_r2;
        logic [OP_BITS-1:0] f_pay;
        renamed_instr_t     ins;
        void'($urandom(RNG_SEED));
        rst_n          = 1'b0;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_instr = '0;
        wb             = '0;
        alu_cnt        = credit_cnt_t'(ALU_DEPTH);
        lsu_cnt        = credit_cnt_t'(LSU_DEPTH);
        live           = '0;
        issued_cnt     = 0;
        returned_cnt   = 0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (issue_valid || alu_credit || lsu_credit) begin
                stop_run($sformatf("ERROR @%0t: output active after reset", $time));
            end
        end
        fd = $fopen("verif/issue_cases.txt", "r");
        if (fd == 0) stop_run("Could not open verif/issue_cases.txt");
        while ($fscanf(fd, " %c", ch) == 1) begin
            case (ch)
                "#": skip_line(fd);
                "D": begin
                    rc = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                 f_fu, f_rob, f_prd, f_p1, f_r1, f_p2, f_r2, f_pay);
                    if (rc != 8) stop_run("Malformed dispatch line in the case file");
                    ins.fu         = fu_class_t'(f_fu[0]);
                    ins.rob_tag    = f_rob[ROB_BITS-1:0];
                    ins.prd        = f_prd[PHYS_REG_BITS-1:0];
                    ins.prs1       = f_p1[PHYS_REG_BITS-1:0];
                    ins.prs1_ready = f_r1[0];
                    ins.prs2       = f_p2[PHYS_REG_BITS-1:0];
                    ins.prs2_ready = f_r2[0];
                    ins.payload    = f_pay;
                    send_dispatch(ins);
                end
                "W": begin
                    rc = $fscanf(fd, "%h", val);
                    send_wake(val[PHYS_REG_BITS-1:0]);
                end
                "F": send_flush();
                "X": begin
                    rc = $fscanf(fd, " %c %h", ch, n);
                    repeat (n) begin
                        rc = $fscanf(fd, "%h", val);
                        if (ch == "A") exp_alu.push_back(val[ROB_BITS-1:0]);
                        else exp_lsu.push_back(val[ROB_BITS-1:0]);
                    end
                end
                "P": wait_drain();
                default: stop_run("Unknown command in the case file");
            endcase
        end
        $fclose(fd);
        waited = 0;
        while (credit_due.size() != 0) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) stop_run("Timed out returning issue credits");
        end
        next_cycle();
        if (issued_cnt == returned_cnt && exp_alu.size() == 0 && exp_lsu.size() == 0
            && obs_alu.size() == 0 && obs_lsu.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_run("Issues or issue credits left over at the end of the run");
        end
    end

endmodule
